/* common/dla_pkg.sv */
// Walker sequencing and seed-shape definitions for the DLA engine.
// Imported by the walker, the top level and the testbench.
package dla_pkg;

    // ----------------------------------------------
    // Walker FSM states
    // ----------------------------------------------
    // Clear and seed run once per start, then
    // SPAWN..MOVE loop once per particle
    typedef enum logic [2:0] {
        IDLE   = 3'd0,   // waiting for start
        CLEAR  = 3'd1,   // zero every pixel
        SEED   = 3'd2,   // plant initial cluster
        SPAWN  = 3'd3,   // new particle from LFSR
        PROBE  = 3'd4,   // four neighbour reads
        DECIDE = 3'd5,   // wait for read data
        STICK  = 3'd6,   // freeze particle in place
        MOVE   = 3'd7    // one random step
    } walk_state_t;

    // ----------------------------------------------
    // Seed shapes
    // ----------------------------------------------
    // Point sits at the frame centre, line fills the bottom row
    typedef enum logic {
        SEED_POINT = 1'b0,
        SEED_LINE  = 1'b1
    } seed_type_t;

endpackage

/* common/fb_pkg.sv */
// Frame-buffer geometry, credit depth and request opcodes.
// Imported by the bus interface and every memory client.
package fb_pkg;

    // Bits per coordinate, frame is square
    localparam int COORD_W    = 5;
    // Pixel address is {row, column}
    localparam int ADDR_W     = 2 * COORD_W;
    localparam int FB_DEPTH   = 1 << ADDR_W;

    // Credits per client, also the per-client queue depth
    localparam int FB_CREDITS = 2;

    // Request opcode
    typedef enum logic {
        FB_READ  = 1'b0,
        FB_WRITE = 1'b1
    } fb_op_t;

endpackage

/* common/fb_if.sv */
// One client's link to the frame store.
// Requests go out, read data and credit returns come back.
`timescale 1ns/1ps

interface fb_if;
    import fb_pkg::*;

    // Client side request, one cycle per credit spent
    logic              req_valid;
    fb_op_t            op;
    logic [ADDR_W-1:0] addr;
    logic              wdata;

    // Store side completion
    logic              rvalid;
    logic              rdata;
    // One pulse per finished request
    logic              credit_ret;

    modport client (
        output req_valid, op, addr, wdata,
        input  rvalid, rdata, credit_ret
    );

    modport store (
        input  req_valid, op, addr, wdata,
        output rvalid, rdata, credit_ret
    );

endinterface

/* dla/dla_walker.sv */
// DLA growth engine: clears the frame, plants the seed, then walks particles
// until they touch the cluster. Talks to the frame store over a credit bus.
`timescale 1ns/1ps

module dla_walker #(
    parameter int          N_PARTICLES = 40,
    parameter int          MAX_STEPS   = 4096,
    parameter logic [15:0] LFSR_SEED   = 16'hace1
) (
    input  logic                 sys_clk,
    input  logic                 reset,
    input  logic                 start,
    input  dla_pkg::seed_type_t  dla_type,
    output logic                 busy,
    output logic                 done,
    fb_if.client                 bus
);
    import dla_pkg::*;
    import fb_pkg::*;

    localparam int PART_W = $clog2(N_PARTICLES + 1);
    localparam int STEP_W = $clog2(MAX_STEPS + 1);
    localparam int CRED_W = $clog2(FB_CREDITS + 1);
    localparam logic [COORD_W-1:0] CENTER = COORD_W'(1 << (COORD_W - 1));

    walk_state_t        state;
    seed_type_t         seed_q;
    logic [15:0]        lfsr;
    logic [15:0]        lfsr_nxt;
    logic [COORD_W-1:0] pos_x;
    logic [COORD_W-1:0] pos_y;
    logic [ADDR_W-1:0]  clr_addr;
    logic [COORD_W-1:0] seed_col;
    logic [1:0]         nb_idx;
    logic [2:0]         rd_out;
    logic               hit;
    logic               wr_sent;
    logic [PART_W-1:0]  part_cnt;
    logic [STEP_W-1:0]  step_cnt;
    logic [CRED_W-1:0]  credits;
    logic               want;
    logic               issue;
    logic               last_part;
    fb_op_t             req_op;
    logic [ADDR_W-1:0]  req_addr;
    logic               req_wdata;

    // Fibonacci LFSR, taps 16 14 13 11
    assign lfsr_nxt  = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
    assign last_part = (part_cnt == PART_W'(N_PARTICLES - 1));
    assign busy      = (state != IDLE);

    // ----------------------------------------------
    // Request generation
    // ----------------------------------------------
    always_comb begin
        want      = 1'b0;
        req_op    = FB_WRITE;
        req_addr  = {pos_y, pos_x};
        req_wdata = 1'b1;
        case (state)
            CLEAR: begin
                want      = 1'b1;
                req_addr  = clr_addr;
                req_wdata = 1'b0;
            end
            SEED: begin
                want     = 1'b1;
                // Bottom row for the line seed
                req_addr = (seed_q == SEED_POINT) ? {CENTER, CENTER}
                                                  : {{COORD_W{1'b1}}, seed_col};
            end
            PROBE: begin
                want   = 1'b1;
                req_op = FB_READ;
                // Right, left, down, up, all wrapping
                case (nb_idx)
                    2'd0:    req_addr = {pos_y, pos_x + 1'b1};
                    2'd1:    req_addr = {pos_y, pos_x - 1'b1};
                    2'd2:    req_addr = {pos_y + 1'b1, pos_x};
                    default: req_addr = {pos_y - 1'b1, pos_x};
                endcase
            end
            STICK:   want = !wr_sent;
            default: want = 1'b0;
        endcase
        // Only spend a credit we actually hold
        issue = want && (credits != '0);
    end

    assign bus.req_valid = issue;
    assign bus.op        = req_op;
    assign bus.addr      = req_addr;
    assign bus.wdata     = req_wdata;

    // ----------------------------------------------
    // Sequencer
    // ----------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state    <= IDLE;
            seed_q   <= SEED_POINT;
            done     <= 1'b0;
            credits  <= CRED_W'(FB_CREDITS);
            rd_out   <= '0;
            hit      <= 1'b0;
            wr_sent  <= 1'b0;
            lfsr     <= LFSR_SEED;
            pos_x    <= '0;
            pos_y    <= '0;
            clr_addr <= '0;
            seed_col <= '0;
            nb_idx   <= '0;
            part_cnt <= '0;
            step_cnt <= '0;
        end else begin
            done    <= 1'b0;
            credits <= credits - CRED_W'(issue) + CRED_W'(bus.credit_ret);
            // Reads in flight for the current probe
            rd_out  <= rd_out + 3'(issue && (req_op == FB_READ)) - 3'(bus.rvalid);
            // Any occupied neighbour makes the particle stick
            if (bus.rvalid && bus.rdata)
                hit <= 1'b1;

            case (state)
                IDLE: if (start) begin
                    lfsr     <= LFSR_SEED;
                    seed_q   <= dla_type;
                    clr_addr <= '0;
                    seed_col <= '0;
                    part_cnt <= '0;
                    wr_sent  <= 1'b0;
                    state    <= CLEAR;
                end
                CLEAR: if (issue) begin
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == '1)
                        state <= SEED;
                end
                SEED: if (issue) begin
                    seed_col <= seed_col + 1'b1;
                    if (seed_q == SEED_POINT || seed_col == '1)
                        state <= SPAWN;
                end
                SPAWN: begin
                    lfsr     <= lfsr_nxt;
                    pos_x    <= lfsr_nxt[COORD_W-1:0];
                    pos_y    <= lfsr_nxt[2*COORD_W-1:COORD_W];
                    step_cnt <= '0;
                    nb_idx   <= '0;
                    hit      <= 1'b0;
                    state    <= PROBE;
                end
                PROBE: if (issue) begin
                    nb_idx <= nb_idx + 1'b1;
                    if (nb_idx == 2'd3)
                        state <= DECIDE;
                end
                DECIDE: if (rd_out == '0) begin
                    if (hit) begin
                        state <= STICK;
                    end else if (step_cnt == STEP_W'(MAX_STEPS)) begin
                        // Walked too far, drop it
                        if (last_part) begin
                            state <= IDLE;
                            done  <= 1'b1;
                        end else begin
                            part_cnt <= part_cnt + 1'b1;
                            state    <= SPAWN;
                        end
                    end else begin
                        state <= MOVE;
                    end
                end
                STICK: begin
                    if (!wr_sent) begin
                        if (issue && last_part) begin
                            wr_sent <= 1'b1;
                        end else if (issue) begin
                            part_cnt <= part_cnt + 1'b1;
                            state    <= SPAWN;
                        end
                    end else if (credits == CRED_W'(FB_CREDITS)) begin
                        // Final write has landed
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                MOVE: begin
                    lfsr <= lfsr_nxt;
                    case (lfsr_nxt[1:0])
                        2'd0:    pos_x <= pos_x + 1'b1;
                        2'd1:    pos_x <= pos_x - 1'b1;
                        2'd2:    pos_y <= pos_y + 1'b1;
                        default: pos_y <= pos_y - 1'b1;
                    endcase
                    step_cnt <= step_cnt + 1'b1;
                    nb_idx   <= '0;
                    hit      <= 1'b0;
                    state    <= PROBE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* verilog/frame_store.sv */
// Single-port frame memory shared by two credit-based clients.
// Each client has its own small queue; service alternates under contention.
`timescale 1ns/1ps

module frame_store (
    input  logic sys_clk,
    input  logic reset,
    fb_if.store  walk,
    fb_if.store  scan
);
    import fb_pkg::*;

    localparam int N_CLI = 2;
    localparam int PTR_W = (FB_CREDITS > 1) ? $clog2(FB_CREDITS) : 1;
    localparam int CNT_W = $clog2(FB_CREDITS + 1);

    // Client 0 is the walker, client 1 the scanout
    logic [N_CLI-1:0]  req_v;
    fb_op_t            req_op    [N_CLI];
    logic [ADDR_W-1:0] req_addr  [N_CLI];
    logic              req_wdata [N_CLI];

    fb_op_t            q_op    [N_CLI][FB_CREDITS];
    logic [ADDR_W-1:0] q_addr  [N_CLI][FB_CREDITS];
    logic              q_wdata [N_CLI][FB_CREDITS];
    logic [PTR_W-1:0]  wr_ptr  [N_CLI];
    logic [PTR_W-1:0]  rd_ptr  [N_CLI];
    logic [CNT_W-1:0]  q_cnt   [N_CLI];
    logic [N_CLI-1:0]  q_ne;
    logic [N_CLI-1:0]  q_pop;

    logic              mem [FB_DEPTH];
    logic              prio;
    logic              serve;
    logic              sel;
    fb_op_t            sel_op;
    logic [ADDR_W-1:0] sel_addr;
    logic              sel_wdata;
    logic              rsp_valid;
    logic              rsp_client;
    logic              rsp_read;
    logic              rsp_data;

    assign req_v     = {scan.req_valid, walk.req_valid};
    assign req_op    = '{walk.op, scan.op};
    assign req_addr  = '{walk.addr, scan.addr};
    assign req_wdata = '{walk.wdata, scan.wdata};

    // ----------------------------------------------
    // Arbitration
    // ----------------------------------------------
    always_comb begin
        for (int c = 0; c < N_CLI; c++)
            q_ne[c] = (q_cnt[c] != '0);
        serve = |q_ne;
        // Round robin only matters when both are waiting
        sel   = (&q_ne) ? prio : q_ne[1];
        for (int c = 0; c < N_CLI; c++)
            q_pop[c] = serve && (sel == 1'(c));
        sel_op    = q_op[sel][rd_ptr[sel]];
        sel_addr  = q_addr[sel][rd_ptr[sel]];
        sel_wdata = q_wdata[sel][rd_ptr[sel]];
    end

    // Queue payload
    always_ff @(posedge sys_clk) begin
        for (int c = 0; c < N_CLI; c++) begin
            if (req_v[c]) begin
                q_op[c][wr_ptr[c]]    <= req_op[c];
                q_addr[c][wr_ptr[c]]  <= req_addr[c];
                q_wdata[c][wr_ptr[c]] <= req_wdata[c];
            end
        end
    end

    // Queue pointers, counts and return strobe
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int c = 0; c < N_CLI; c++) begin
                wr_ptr[c] <= '0;
                rd_ptr[c] <= '0;
                q_cnt[c]  <= '0;
            end
            prio      <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            for (int c = 0; c < N_CLI; c++) begin
                if (req_v[c])
                    wr_ptr[c] <= (wr_ptr[c] == PTR_W'(FB_CREDITS - 1)) ? '0 : wr_ptr[c] + 1'b1;
                if (q_pop[c])
                    rd_ptr[c] <= (rd_ptr[c] == PTR_W'(FB_CREDITS - 1)) ? '0 : rd_ptr[c] + 1'b1;
                q_cnt[c] <= q_cnt[c] + CNT_W'(req_v[c]) - CNT_W'(q_pop[c]);
            end
            if (&q_ne)
                prio <= ~sel;
            rsp_valid <= serve;
        end
    end

    // ----------------------------------------------
    // Memory and return stage
    // ----------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (serve && sel_op == FB_WRITE)
            mem[sel_addr] <= sel_wdata;
        rsp_data   <= mem[sel_addr];
        rsp_client <= sel;
        rsp_read   <= (sel_op == FB_READ);
    end

    // Credit back for every op, data only for reads
    assign walk.credit_ret = rsp_valid && !rsp_client;
    assign walk.rvalid     = rsp_valid && rsp_read && !rsp_client;
    assign walk.rdata      = rsp_data;
    assign scan.credit_ret = rsp_valid && rsp_client;
    assign scan.rvalid     = rsp_valid && rsp_read && rsp_client;
    assign scan.rdata      = rsp_data;

endmodule

/* verilog/fb_scanout.sv */
// Raster reader for the frame store, turns read returns into a pixel stream.
// Keeps reading while scan_enable is high and always finishes a frame.
`timescale 1ns/1ps

module fb_scanout (
    input  logic sys_clk,
    input  logic reset,
    input  logic scan_enable,
    fb_if.client bus,
    output logic pixel_valid,
    output logic pixel,
    output logic frame_start
);
    import fb_pkg::*;

    localparam int CRED_W = $clog2(FB_CREDITS + 1);

    logic [CRED_W-1:0] credits;
    // Next address to request
    logic [ADDR_W-1:0] req_addr;
    // Address of the next returned pixel
    logic [ADDR_W-1:0] rsp_addr;
    logic              issue;

    // ----------------------------------------------
    // Request side
    // ----------------------------------------------
    // A frame already started runs to its last address
    assign issue = (credits != '0) && (scan_enable || req_addr != '0);

    assign bus.req_valid = issue;
    assign bus.op        = FB_READ;
    assign bus.addr      = req_addr;
    assign bus.wdata     = 1'b0;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            credits     <= CRED_W'(FB_CREDITS);
            req_addr    <= '0;
            rsp_addr    <= '0;
            pixel_valid <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            credits <= credits - CRED_W'(issue) + CRED_W'(bus.credit_ret);
            if (issue)
                req_addr <= req_addr + 1'b1;
            // Responses return in order, so a counter tags them
            if (bus.rvalid)
                rsp_addr <= rsp_addr + 1'b1;
            pixel_valid <= bus.rvalid;
            frame_start <= bus.rvalid && (rsp_addr == '0);
        end
    end

    // ----------------------------------------------
    // Pixel data
    // ----------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (bus.rvalid)
            pixel <= bus.rdata;
    end

endmodule

/* verilog/dla_frame_buffer.sv */
// DLA engine top: walker and scanout share one frame store.
// Set the particle count, walk limit and LFSR seed here.
`timescale 1ns/1ps

module dla_frame_buffer #(
    parameter int          N_PARTICLES = 40,
    parameter int          MAX_STEPS   = 4096,
    parameter logic [15:0] LFSR_SEED   = 16'hace1
) (
    input  logic                sys_clk,
    input  logic                reset,
    input  logic                start,
    input  dla_pkg::seed_type_t dla_type,
    output logic                busy,
    output logic                done,
    input  logic                scan_enable,
    output logic                pixel_valid,
    output logic                pixel,
    output logic                frame_start
);

    // One credit bus per client
    fb_if walk_bus ();
    fb_if scan_bus ();

    // ----------------------------------------------
    // Clients
    // ----------------------------------------------
    dla_walker #(
        .N_PARTICLES (N_PARTICLES),
        .MAX_STEPS   (MAX_STEPS),
        .LFSR_SEED   (LFSR_SEED)
    ) u_dla_walker (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .start       (start),
        .dla_type    (dla_type),
        .busy        (busy),
        .done        (done),
        .bus         (walk_bus.client)
    );

    fb_scanout u_fb_scanout (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .scan_enable (scan_enable),
        .bus         (scan_bus.client),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .frame_start (frame_start)
    );

    // Shared memory and arbiter
    frame_store u_frame_store (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .walk        (walk_bus.store),
        .scan        (scan_bus.store)
    );

endmodule

/* sim/dla_walker_assertions.sv */
// Concurrent checks on the walker credit counter and status outputs.
// Attached to every dla_walker instance through the bind at the end.
`timescale 1ns/1ps

module dla_walker_assertions #(
    parameter int CRED_W = 2
) (
    input logic              sys_clk,
    input logic              reset,
    input logic [CRED_W-1:0] credits,
    input logic              busy,
    input logic              done,
    input logic              req_valid,
    input logic              credit_ret
);
    import fb_pkg::*;

    localparam int FLT_W = CRED_W + 1;

    // Requests still waiting for their credit, counted from the bus
    logic [FLT_W-1:0] in_flight;

    always_ff @(posedge sys_clk) begin
        if (reset)
            in_flight <= '0;
        else
            in_flight <= in_flight + FLT_W'(req_valid) - FLT_W'(credit_ret);
    end

    credit_limit: assert property (@(posedge sys_clk) disable iff (reset)
        credits <= CRED_W'(FB_CREDITS))
        else $error("walker credit count above the store queue depth");

    // Done only once idle and every credit is back
    busy_done_excl: assert property (@(posedge sys_clk) disable iff (reset)
        done |-> (!busy && credits == CRED_W'(FB_CREDITS)))
        else $error("walker done while busy or with credits outstanding");

    req_needs_credit: assert property (@(posedge sys_clk) disable iff (reset)
        req_valid |-> (in_flight < FLT_W'(FB_CREDITS)))
        else $error("walker request issued without a credit");

endmodule

bind dla_walker dla_walker_assertions #(.CRED_W(CRED_W)) u_walker_assertions (
    .sys_clk    (sys_clk),
    .reset      (reset),
    .credits    (credits),
    .busy       (busy),
    .done       (done),
    .req_valid  (bus.req_valid),
    .credit_ret (bus.credit_ret)
);

/* sim/tb_dla_frame_buffer.sv */
// Testbench for the DLA engine: runs both seed shapes, scans frames out
// and compares them with a software replay of the walker.
`timescale 1ns/1ps

module tb_dla_frame_buffer;
    import dla_pkg::*;

    localparam int          N_PARTICLES = 40;
    localparam int          MAX_STEPS   = 4096;
    localparam logic [15:0] LFSR_SEED   = 16'hace1;
    localparam int          LIMIT       = 2 * N_PARTICLES * MAX_STEPS * 12 + 20000;
    localparam int          NPIX        = 1024;

    logic       sys_clk;
    logic       reset;
    logic       start;
    seed_type_t dla_type;
    logic       busy;
    logic       done;
    logic       scan_enable;
    logic       pixel_valid;
    logic       pixel;
    logic       frame_start;

    bit          model_img [NPIX];
    bit          got_img   [NPIX];
    logic [31:0] rnd;
    int          cycles;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          err_mark;

    dla_frame_buffer #(
        .N_PARTICLES (N_PARTICLES),
        .MAX_STEPS   (MAX_STEPS),
        .LFSR_SEED   (LFSR_SEED)
    ) DUT (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .start       (start),
        .dla_type    (dla_type),
        .busy        (busy),
        .done        (done),
        .scan_enable (scan_enable),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .frame_start (frame_start)
    );

    // 4 ns clock
    always #2 sys_clk = ~sys_clk;

    // Run limit sized for the worst case of two full runs
    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run passed %0d cycles without finishing", LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ----------------------------------------------
    // Helpers
    // ----------------------------------------------
    // Stimulus LFSR, taps 32 22 2 1
    function automatic logic rand_bit();
        rnd = {rnd[30:0], rnd[31] ^ rnd[21] ^ rnd[1] ^ rnd[0]};
        return rnd[0];
    endfunction

    // Walker LFSR, taps 16 14 13 11
    function automatic logic [15:0] walker_step(input logic [15:0] l);
        return {l[14:0], l[15] ^ l[13] ^ l[12] ^ l[10]};
    endfunction

    function automatic bit occupied(input logic [4:0] x, input logic [4:0] y);
        return model_img[{y, x}];
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark)
            tests_failed++;
        $display("Test %0d %s: %s", tests_run, name, (errors == err_mark) ? "pass" : "fail");
        err_mark = errors;
    endtask

    // Replays clear, seed and every particle walk on model_img
    task automatic build_model(input seed_type_t t);
        logic [15:0] l;
        logic [4:0]  x;
        logic [4:0]  y;
        int          steps;
        bit          fin;
        for (int i = 0; i < NPIX; i++)
            model_img[i] = 1'b0;
        if (t == SEED_POINT)
            model_img[16 * 32 + 16] = 1'b1;
        else
            for (int c = 0; c < 32; c++)
                model_img[31 * 32 + c] = 1'b1;
        l = LFSR_SEED;
        for (int p = 0; p < N_PARTICLES; p++) begin
            l = walker_step(l);
            x = l[4:0];
            y = l[9:5];
            steps = 0;
            fin = 1'b0;
            while (!fin) begin
                if (occupied(x + 5'd1, y) || occupied(x - 5'd1, y) ||
                    occupied(x, y + 5'd1) || occupied(x, y - 5'd1)) begin
                    model_img[{y, x}] = 1'b1;
                    fin = 1'b1;
                end else if (steps == MAX_STEPS) begin
                    fin = 1'b1;
                end else begin
                    l = walker_step(l);
                    case (l[1:0])
                        2'd0:    x = x + 5'd1;
                        2'd1:    x = x - 5'd1;
                        2'd2:    y = y + 5'd1;
                        default: y = y - 5'd1;
                    endcase
                    steps++;
                end
            end
        end
    endtask

    task automatic pulse_start(input seed_type_t t);
        @(negedge sys_clk);
        dla_type = t;
        start = 1'b1;
        @(negedge sys_clk);
        start = 1'b0;
    endtask

    // Grabs one whole frame beginning at frame_start, then stops the scan
    task automatic capture_frame();
        int idx;
        scan_enable = 1'b1;
        do @(negedge sys_clk); while (!(pixel_valid && frame_start));
        scan_enable = 1'b0;
        got_img[0] = pixel;
        idx = 1;
        while (idx < NPIX) begin
            @(negedge sys_clk);
            if (pixel_valid) begin
                got_img[idx] = pixel;
                idx++;
            end
        end
    endtask

    task automatic compare_frame();
        for (int i = 0; i < NPIX; i++)
            check($sformatf("pixel[%0d]", i), model_img[i], got_img[i]);
    endtask

    // ----------------------------------------------
    // Test sequence
    // ----------------------------------------------
    initial begin
        int   count;
        int   tick;
        bit   in_frame;
        bit   exempt;
        bit   was_busy;
        sys_clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        dla_type = SEED_POINT;
        scan_enable = 1'b0;
        rnd = 32'h989e35c4;
        cycles = 0;
        errors = 0;
        err_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (8) @(negedge sys_clk);
        reset = 1'b0;

        // Quiet outputs after reset
        repeat (20) begin
            @(negedge sys_clk);
            check("busy", 0, busy);
            check("done", 0, done);
            check("pixel_valid", 0, pixel_valid);
            check("frame_start", 0, frame_start);
        end
        end_test("idle after reset");

        // Point seed run
        pulse_start(SEED_POINT);
        do begin
            was_busy = busy;
            @(negedge sys_clk);
        end while (!done);
        check("busy before done", 1, was_busy);
        check("busy", 0, busy);
        end_test("point run completes");

        build_model(SEED_POINT);
        capture_frame();
        compare_frame();
        end_test("point frame matches model");

        // Line seed run with random scan gating
        build_model(SEED_LINE);
        pulse_start(SEED_LINE);
        count = 0;
        tick = 0;
        in_frame = 1'b0;
        exempt = 1'b1;
        while (!done) begin
            @(negedge sys_clk);
            tick++;
            if (tick % 200 == 0)
                scan_enable = rand_bit();
            if (pixel_valid) begin
                if (frame_start) begin
                    if (in_frame)
                        check("frame length", NPIX, count);
                    in_frame = 1'b1;
                    count = 0;
                    // Frames starting before seeding may still hold old pixels
                    exempt = (DUT.u_dla_walker.state inside {IDLE, CLEAR, SEED});
                end
                if (in_frame && !exempt && pixel && count < NPIX)
                    check($sformatf("stream pixel[%0d]", count), model_img[count], pixel);
                count++;
            end
        end
        check("busy", 0, busy);
        end_test("line run streams whole frames");

        capture_frame();
        compare_frame();
        end_test("line frame matches model");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
common/dla_pkg.sv
common/fb_pkg.sv
common/fb_if.sv
dla/dla_walker.sv
verilog/frame_store.sv
verilog/fb_scanout.sv
verilog/dla_frame_buffer.sv
sim/dla_walker_assertions.sv
sim/tb_dla_frame_buffer.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_dla_frame_buffer
FILELIST   := src.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
